// File: hdl/drive_clock_gen.sv
//----------------------------------------------------------
// drive clock generator
// 1 MHz / 2 MHz phase strobes and 8 MHz controller strobe
//----------------------------------------------------------
module drive_clock_gen (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       ce_i,
	input  logic       pause_i,
	output logic [1:0] ph2_r_o,
	output logic [1:0] ph2_f_o,
	output logic       wd_ce_o
);

	// divider over the 16 MHz enable
	logic [3:0] div;
	// first pause stage, taken every clock
	logic       run_q;
	// second stage, only updated at divider phase 0
	logic       ena;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			div     <= 4'd0;
			run_q   <= 1'b0;
			ena     <= 1'b0;
			ph2_r_o <= 2'b00;
			ph2_f_o <= 2'b00;
			wd_ce_o <= 1'b0;
		end else begin
			run_q <= ~pause_i;

			// strobes are one clock wide
			ph2_r_o <= 2'b00;
			ph2_f_o <= 2'b00;
			wd_ce_o <= 1'b0;

			if (ce_i) begin
				div <= div + 4'd1;
				if (div == 4'd0)
					ena <= run_q;

				// 1 MHz, rise and fall 8 enables apart
				ph2_r_o[0] <= ena && !div[3] && (div[2:0] == 3'd0);
				ph2_f_o[0] <= ena &&  div[3] && (div[2:0] == 3'd0);
				// 2 MHz
				ph2_r_o[1] <= ena && !div[2] && (div[1:0] == 2'd0);
				ph2_f_o[1] <= ena &&  div[2] && (div[1:0] == 2'd0);
				// 8 MHz controller
				wd_ce_o    <= ena && !div[0];
			end
		end
	end

endmodule

// File: hdl/drive_core.sv
//----------------------------------------------------------
// reduced drive core
// steps through its ROM at 1 MHz and drives the bus from it
//----------------------------------------------------------
module drive_core import iec_drive_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              drv_reset_i,
	input  logic              ph2_r1_i,
	input  logic              atn_i,
	input  logic [7:0]        rom_data_i,
	output logic [ROM_AW-1:0] rom_addr_o,
	output logic              data_o,
	output logic              clk_o,
	output logic              fclk_o,
	output logic              led_o,
	output logic [7:0]        par_data_o,
	output logic              par_stb_o
);

	// byte currently applied to the outputs
	logic [7:0] cur_byte;
	// parallel strobe, active low
	logic       stb_n;
	logic       atn_ack;

	//----------------------------------------------------------
	// sequencer
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i || drv_reset_i) begin
			rom_addr_o <= '0;
			// all lines released while held in reset
			cur_byte   <= 8'hFF;
			stb_n      <= 1'b1;
		end else begin
			stb_n <= 1'b1;
			if (ph2_r1_i) begin
				// fetched byte belongs to the address held until now
				cur_byte   <= rom_data_i;
				// wraps at 32K, smaller images fold in the arbiter
				rom_addr_o <= rom_addr_o + 1'b1;
				stb_n      <= 1'b0;
			end
		end
	end

	//----------------------------------------------------------
	// byte field decode
	//----------------------------------------------------------
	// hardware ATN acknowledge pulls data low
	assign atn_ack = !atn_i && !cur_byte[BIT_ATN_NOACK];

	assign data_o     = cur_byte[BIT_DATA] && !atn_ack;
	assign clk_o      = cur_byte[BIT_CLK];
	assign fclk_o     = cur_byte[BIT_FCLK];
	assign led_o      = cur_byte[BIT_LED];

	// whole byte goes out on the parallel port
	assign par_data_o = cur_byte;
	assign par_stb_o  = stb_n;

endmodule

// File: hdl/drive_rom_bank.sv
//----------------------------------------------------------
// drive ROM bank
// three 32K x 8 images, host write port, shared read address
//----------------------------------------------------------
module drive_rom_bank import iec_drive_pkg::*; (
	input  logic                 clk,
	input  logic [DRV_IDX_W-1:0] rom_sel_i,
	input  logic [ROM_AW-1:0]    rom_addr_i,
	input  logic [7:0]           rom_data_i,
	input  logic                 rom_wr_i,
	input  logic [ROM_AW-1:0]    rd_addr_i,
	output logic [7:0]           rd_data_o [NUM_ROMS]
);

	//----------------------------------------------------------
	// one simple dual port RAM per image
	//----------------------------------------------------------
	for (genvar g = 0; g < NUM_ROMS; g++) begin : g_img
		logic [7:0] mem [2**ROM_AW];
		logic [7:0] rd_q;
		logic       wr_en;

		// image select decode
		assign wr_en = rom_wr_i && (rom_sel_i == DRV_IDX_W'(g));

		always_ff @(posedge clk) begin
			if (wr_en)
				mem[rom_addr_i] <= rom_data_i;
		end

		// registered read, one clock latency
		always_ff @(posedge clk) begin
			rd_q <= mem[rd_addr_i];
		end

		assign rd_data_o[g] = rd_q;
	end

endmodule

// File: hdl/iec_bus_merge.sv
//----------------------------------------------------------
// serial and parallel bus merge
// input sync, drive reset sync, wired-AND of drive outputs
//----------------------------------------------------------
module iec_bus_merge import iec_drive_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic [NUM_DRIVES-1:0] drv_reset_i,
	input  logic                  iec_atn_i,
	input  logic [NUM_DRIVES-1:0] drv_data_i,
	input  logic [NUM_DRIVES-1:0] drv_clk_i,
	input  logic [NUM_DRIVES-1:0] drv_fclk_i,
	input  logic [NUM_DRIVES-1:0] drv_led_i,
	input  logic [7:0]            drv_par_data_i [NUM_DRIVES],
	input  logic [NUM_DRIVES-1:0] drv_par_stb_i,
	input  logic [NUM_DRIVES-1:0] ext_en_i,
	output logic [NUM_DRIVES-1:0] reset_drv_o,
	output logic                  atn_o,
	output logic                  iec_data_o,
	output logic                  iec_clk_o,
	output logic                  iec_fclk_o,
	output logic [NUM_DRIVES-1:0] led_o,
	output logic [7:0]            par_data_o,
	output logic                  par_stb_o
);

	logic [NUM_DRIVES-1:0] rst_meta;
	logic                  atn_meta;

	//----------------------------------------------------------
	// two-flop synchronizers
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rst_meta    <= '0;
			reset_drv_o <= '0;
			// ATN idles released
			atn_meta    <= 1'b1;
			atn_o       <= 1'b1;
		end else begin
			rst_meta    <= drv_reset_i;
			reset_drv_o <= rst_meta;
			atn_meta    <= iec_atn_i;
			atn_o       <= atn_meta;
		end
	end

	// open collector bus, a drive in reset lets go
	assign iec_data_o = &(drv_data_i | reset_drv_o);
	assign iec_clk_o  = &(drv_clk_i  | reset_drv_o);
	assign iec_fclk_o = &(drv_fclk_i | reset_drv_o);

	assign led_o = drv_led_i & ~reset_drv_o;

	//----------------------------------------------------------
	// parallel port, only drives with the extension take part
	//----------------------------------------------------------
	assign par_stb_o = &(drv_par_stb_i | ~ext_en_i);

	always_comb begin
		par_data_o = 8'hFF;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (ext_en_i[i])
				par_data_o = par_data_o & drv_par_data_i[i];
		end
	end

endmodule

// File: hdl/iec_drive_pkg.sv
//----------------------------------------------------------
// floppy subsystem shared definitions
// drive count, ROM geometry, model codes and byte fields
//----------------------------------------------------------
package iec_drive_pkg;

	//----------------------------------------------------------
	// drive count
	//----------------------------------------------------------
	// works for 1 to 4 drives
	localparam int NUM_DRIVES = 2;
	localparam int DRV_IDX_W  = 2;

	//----------------------------------------------------------
	// ROM geometry
	//----------------------------------------------------------
	// 32 KB per image
	localparam int ROM_AW   = 15;
	// images actually stored, the 1571CR has none
	localparam int NUM_ROMS = 3;

	// parallel port extension
	localparam bit PARPORT_EN = 1'b1;

	// drive models, value doubles as the image index
	typedef enum logic [1:0] {
		MODEL_1541   = 2'd0,
		MODEL_1570   = 2'd1,
		MODEL_1571   = 2'd2,
		MODEL_1571CR = 2'd3
	} drive_model_e;

	// image size, also the mask for address bits 14:13
	typedef enum logic [1:0] {
		ROM_8K  = 2'd0,
		ROM_16K = 2'd1,
		ROM_32K = 2'd3
	} rom_size_e;

	//----------------------------------------------------------
	// fields of a fetched ROM byte
	//----------------------------------------------------------
	localparam int BIT_DATA      = 0;
	localparam int BIT_CLK       = 1;
	localparam int BIT_FCLK      = 2;
	localparam int BIT_LED       = 3;
	localparam int BIT_ATN_NOACK = 4;

endpackage

// File: hdl/iec_multi_drive.sv
//----------------------------------------------------------
// multi-drive floppy subsystem top level
// drive cores sharing one ROM bank on the serial bus
//----------------------------------------------------------
module iec_multi_drive import iec_drive_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  ce_i,
	input  logic                  pause_i,
	input  logic [NUM_DRIVES-1:0] drv_reset_i,
	input  drive_model_e          drv_mode_i [NUM_DRIVES],
	// serial bus, active low open collector
	input  logic                  iec_atn_i,
	input  logic                  iec_data_i,
	input  logic                  iec_clk_i,
	input  logic                  iec_fclk_i,
	output logic                  iec_data_o,
	output logic                  iec_clk_o,
	output logic                  iec_fclk_o,
	// parallel port
	input  logic [7:0]            par_data_i,
	input  logic                  par_stb_i,
	output logic [7:0]            par_data_o,
	output logic                  par_stb_o,
	output logic [NUM_DRIVES-1:0] led_o,
	// ROM load port
	input  logic [DRV_IDX_W-1:0]  rom_sel_i,
	input  logic [ROM_AW-1:0]     rom_addr_i,
	input  logic [7:0]            rom_data_i,
	input  logic                  rom_wr_i
);

	logic [1:0]            ph2_r;
	logic [1:0]            ph2_f;
	rom_size_e             rom_size [NUM_DRIVES];
	logic [NUM_DRIVES-1:0] ext_en;
	logic [NUM_DRIVES-1:0] reset_drv;
	logic                  atn_sync;
	logic [ROM_AW-1:0]     bank_addr;
	logic [7:0]            bank_data [NUM_ROMS];
	logic [ROM_AW-1:0]     drv_addr [NUM_DRIVES];
	logic [7:0]            drv_rom_data [NUM_DRIVES];
	logic [NUM_DRIVES-1:0] core_data;
	logic [NUM_DRIVES-1:0] core_clk;
	logic [NUM_DRIVES-1:0] core_fclk;
	logic [NUM_DRIVES-1:0] core_led;
	logic [NUM_DRIVES-1:0] core_par_stb;
	logic [7:0]            core_par_data [NUM_DRIVES];

	// no disk controller in the reduced cores, 8 MHz strobe stays open
	drive_clock_gen i_clock_gen (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.ce_i    (ce_i),
		.pause_i (pause_i),
		.ph2_r_o (ph2_r),
		.ph2_f_o (ph2_f),
		.wd_ce_o ()
	);

	rom_size_tracker i_size_tracker (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.rom_sel_i   (rom_sel_i),
		.rom_addr_i  (rom_addr_i),
		.rom_data_i  (rom_data_i),
		.rom_wr_i    (rom_wr_i),
		.drv_mode_i  (drv_mode_i),
		.reset_drv_i (reset_drv),
		.rom_size_o  (rom_size),
		.ext_en_o    (ext_en)
	);

	drive_rom_bank i_rom_bank (
		.clk        (clk),
		.rom_sel_i  (rom_sel_i),
		.rom_addr_i (rom_addr_i),
		.rom_data_i (rom_data_i),
		.rom_wr_i   (rom_wr_i),
		.rd_addr_i  (bank_addr),
		.rd_data_o  (bank_data)
	);

	rom_slot_arbiter i_arbiter (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ph2_f2_i    (ph2_f[1]),
		.drv_addr_i  (drv_addr),
		.drv_mode_i  (drv_mode_i),
		.rom_size_i  (rom_size),
		.bank_data_i (bank_data),
		.bank_addr_o (bank_addr),
		.drv_data_o  (drv_rom_data)
	);

	//----------------------------------------------------------
	// drive cores
	//----------------------------------------------------------
	for (genvar d = 0; d < NUM_DRIVES; d++) begin : g_drive
		drive_core i_core (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.drv_reset_i (reset_drv[d]),
			.ph2_r1_i    (ph2_r[0]),
			.atn_i       (atn_sync),
			.rom_data_i  (drv_rom_data[d]),
			.rom_addr_o  (drv_addr[d]),
			.data_o      (core_data[d]),
			.clk_o       (core_clk[d]),
			.fclk_o      (core_fclk[d]),
			.led_o       (core_led[d]),
			.par_data_o  (core_par_data[d]),
			.par_stb_o   (core_par_stb[d])
		);
	end

	iec_bus_merge i_bus_merge (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.drv_reset_i    (drv_reset_i),
		.iec_atn_i      (iec_atn_i),
		.drv_data_i     (core_data),
		.drv_clk_i      (core_clk),
		.drv_fclk_i     (core_fclk),
		.drv_led_i      (core_led),
		.drv_par_data_i (core_par_data),
		.drv_par_stb_i  (core_par_stb),
		.ext_en_i       (ext_en),
		.reset_drv_o    (reset_drv),
		.atn_o          (atn_sync),
		.iec_data_o     (iec_data_o),
		.iec_clk_o      (iec_clk_o),
		.iec_fclk_o     (iec_fclk_o),
		.led_o          (led_o),
		.par_data_o     (par_data_o),
		.par_stb_o      (par_stb_o)
	);

endmodule

// File: hdl/rom_size_tracker.sv
//----------------------------------------------------------
// ROM size tracker
// learns image sizes while loading, derives parallel enables
//----------------------------------------------------------
module rom_size_tracker import iec_drive_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic [DRV_IDX_W-1:0] rom_sel_i,
	input  logic [ROM_AW-1:0]    rom_addr_i,
	input  logic [7:0]           rom_data_i,
	input  logic                 rom_wr_i,
	input  drive_model_e         drv_mode_i [NUM_DRIVES],
	input  logic [NUM_DRIVES-1:0] reset_drv_i,
	output rom_size_e            rom_size_o [NUM_DRIVES],
	output logic [NUM_DRIVES-1:0] ext_en_o
);

	rom_size_e size_q    [NUM_ROMS];
	logic      empty8k_q [NUM_ROMS];
	logic      data_used;

	// 00 and FF count as filler
	assign data_used = (rom_data_i != 8'h00) && (rom_data_i != 8'hFF);

	// size from the highest touched 8K window
	function automatic rom_size_e window_size(input logic [1:0] hi);
		if (hi[1])
			return ROM_32K;
		if (hi[0])
			return ROM_16K;
		return ROM_8K;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_ROMS; i++) begin
				size_q[i]    <= (i == MODEL_1541) ? ROM_8K : ROM_32K;
				empty8k_q[i] <= 1'b0;
			end
		end else if (rom_wr_i && (rom_sel_i < NUM_ROMS)) begin
			if (rom_addr_i == '0)
				empty8k_q[rom_sel_i] <= 1'b1;
			if (data_used) begin
				size_q[rom_sel_i] <= window_size(rom_addr_i[ROM_AW-1 -: 2]);
				// real code between 0x100 and 0x1FFF
				if ((rom_addr_i[ROM_AW-1 -: 2] == 2'b00) && (rom_addr_i[12:8] != 5'd0))
					empty8k_q[rom_sel_i] <= 1'b0;
			end
		end
	end

	// per drive view of its model's image
	always_comb begin
		for (int d = 0; d < NUM_DRIVES; d++) begin
			if (drv_mode_i[d] == MODEL_1571CR) begin
				rom_size_o[d] = ROM_32K;
				ext_en_o[d]   = 1'b0;
			end else begin
				rom_size_o[d] = size_q[drv_mode_i[d]];
				ext_en_o[d]   = (size_q[drv_mode_i[d]] == ROM_32K) &&
				                empty8k_q[drv_mode_i[d]] && PARPORT_EN &&
				                !reset_drv_i[d];
			end
		end
	end

endmodule

// File: hdl/rom_slot_arbiter.sv
//----------------------------------------------------------
// ROM slot arbiter
// time-slot sharing of the ROM read port among the drives
//----------------------------------------------------------
module rom_slot_arbiter import iec_drive_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              ph2_f2_i,
	input  logic [ROM_AW-1:0] drv_addr_i [NUM_DRIVES],
	input  drive_model_e      drv_mode_i [NUM_DRIVES],
	input  rom_size_e         rom_size_i [NUM_DRIVES],
	input  logic [7:0]        bank_data_i [NUM_ROMS],
	output logic [ROM_AW-1:0] bank_addr_o,
	output logic [7:0]        drv_data_o [NUM_DRIVES]
);

	logic [2:0]        slot;
	logic [7:0]        bank_q [NUM_ROMS];
	logic [ROM_AW-1:0] masked_addr [NUM_DRIVES];

	//----------------------------------------------------------
	// slot counter, restarts every 2 MHz fall, holds at 7
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			slot <= 3'd0;
		else if (ph2_f2_i)
			slot <= 3'd0;
		else if (slot != 3'd7)
			slot <= slot + 3'd1;
	end

	// fold the upper window bits by image size
	always_comb begin
		for (int i = 0; i < NUM_DRIVES; i++) begin
			masked_addr[i] = {drv_addr_i[i][ROM_AW-1 -: 2] & rom_size_i[i],
			                  drv_addr_i[i][ROM_AW-3:0]};
		end
	end

	//----------------------------------------------------------
	// address out in slot i, data back in slot i+3
	//----------------------------------------------------------
	// bank output staged once more so slot i+3 sees drive i's read
	always_ff @(posedge clk) begin
		bank_q <= bank_data_i;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (slot == 3'(i))
				bank_addr_o <= masked_addr[i];
			if (slot == 3'(i + 3)) begin
				// 1571CR has no image and reads all ones
				if (drv_mode_i[i] == MODEL_1571CR)
					drv_data_o[i] <= 8'hFF;
				else
					drv_data_o[i] <= bank_q[drv_mode_i[i]];
			end
		end
	end

endmodule

// File: sources.f
hdl/iec_drive_pkg.sv
hdl/drive_clock_gen.sv
hdl/rom_size_tracker.sv
hdl/drive_rom_bank.sv
hdl/rom_slot_arbiter.sv
hdl/drive_core.sv
hdl/iec_bus_merge.sv
hdl/iec_multi_drive.sv
verification/iec_multi_drive_tb.sv

// File: verification/iec_multi_drive_tb.sv
//----------------------------------------------------------
// multi-drive floppy subsystem testbench
// directed tests of sequencing, parallel port, wrap, ATN, pause
//----------------------------------------------------------
module iec_multi_drive_tb import iec_drive_pkg::*; ();

	// idle byte of the wrap image, ATN acknowledge enabled
	localparam logic [7:0] QUIET = 8'h0F;

	logic                  clk = 1'b0;
	logic                  rst_n_i;
	logic                  ce_i;
	logic                  pause_i;
	logic [NUM_DRIVES-1:0] drv_reset_i;
	drive_model_e          drv_mode [NUM_DRIVES];
	logic                  iec_atn_i;
	logic                  iec_data_i;
	logic                  iec_clk_i;
	logic                  iec_fclk_i;
	logic                  iec_data_o;
	logic                  iec_clk_o;
	logic                  iec_fclk_o;
	logic [7:0]            par_data_i;
	logic                  par_stb_i;
	logic [7:0]            par_data_o;
	logic                  par_stb_o;
	logic [NUM_DRIVES-1:0] led_o;
	logic [DRV_IDX_W-1:0]  rom_sel_i;
	logic [ROM_AW-1:0]     rom_addr_i;
	logic [7:0]            rom_data_i;
	logic                  rom_wr_i;

	// reference images and learned sizes
	logic [7:0] img_mem [NUM_ROMS][2**ROM_AW];
	rom_size_e  exp_size [NUM_ROMS];
	logic       exp_empty8k [NUM_ROMS];
	integer     seed;
	int         fail_count;
	int         exp_addr;
	logic [3:0] prev_bus;

	always #10 clk = ~clk;

	iec_multi_drive i_dut (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i), .pause_i(pause_i),
		.drv_reset_i(drv_reset_i), .drv_mode_i(drv_mode),
		.iec_atn_i(iec_atn_i), .iec_data_i(iec_data_i), .iec_clk_i(iec_clk_i),
		.iec_fclk_i(iec_fclk_i), .iec_data_o(iec_data_o), .iec_clk_o(iec_clk_o),
		.iec_fclk_o(iec_fclk_o), .par_data_i(par_data_i), .par_stb_i(par_stb_i),
		.par_data_o(par_data_o), .par_stb_o(par_stb_o), .led_o(led_o),
		.rom_sel_i(rom_sel_i), .rom_addr_i(rom_addr_i), .rom_data_i(rom_data_i),
		.rom_wr_i(rom_wr_i)
	);

	//----------------------------------------------------------
	// failure reporting and compare tasks
	//----------------------------------------------------------
	task automatic stop_run(input string line);
		fail_count++;
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_run($sformatf("ERR @%0t: %s got %02h expected %02h", $time, what, got, exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("ERR @%0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic check_size(input string what, input rom_size_e got, input rom_size_e exp);
		if (got !== exp)
			stop_run($sformatf("ERR @%0t: %s got %s expected %s", $time, what,
			                   got.name(), exp.name()));
	endtask

	//----------------------------------------------------------
	// reference model helpers
	//----------------------------------------------------------
	function automatic int rom_bytes(input rom_size_e s);
		case (s)
			ROM_8K:  return 8192;
			ROM_16K: return 16384;
			default: return 32768;
		endcase
	endfunction

	function automatic logic [7:0] image_byte(input drive_model_e model, input int addr);
		int off;
		if (model == MODEL_1571CR)
			return 8'hFF;
		off = (addr % (2**ROM_AW)) % rom_bytes(exp_size[model]);
		return img_mem[model][off];
	endfunction

	// serial bus and LED as set by one byte, ATN idle
	function automatic logic [3:0] bus_fields(input logic [7:0] b);
		return {b[BIT_LED], b[BIT_FCLK], b[BIT_CLK], b[BIT_DATA]};
	endfunction

	function automatic logic [3:0] bus_state();
		return {led_o[0], iec_fclk_o, iec_clk_o, iec_data_o};
	endfunction

	function automatic logic expect_ext_en(input drive_model_e model, input logic in_reset);
		if (model == MODEL_1571CR)
			return 1'b0;
		return (exp_size[model] == ROM_32K) && exp_empty8k[model] && PARPORT_EN && !in_reset;
	endfunction

	function automatic logic [NUM_DRIVES-1:0] only_drive0_run();
		logic [NUM_DRIVES-1:0] v;
		v    = '1;
		v[0] = 1'b0;
		return v;
	endfunction

	//----------------------------------------------------------
	// stimulus tasks
	//----------------------------------------------------------
	task automatic write_rom(input int sel, input int addr, input logic [7:0] data);
		@(negedge clk);
		rom_sel_i  = DRV_IDX_W'(sel);
		rom_addr_i = ROM_AW'(addr);
		rom_data_i = data;
		rom_wr_i   = 1'b1;
		img_mem[sel][addr] = data;
		if (addr == 0)
			exp_empty8k[sel] = 1'b1;
		if ((data != 8'h00) && (data != 8'hFF)) begin
			if (addr >= 'h4000)
				exp_size[sel] = ROM_32K;
			else if (addr >= 'h2000)
				exp_size[sel] = ROM_16K;
			else
				exp_size[sel] = ROM_8K;
			if ((addr >= 'h100) && (addr < 'h2000))
				exp_empty8k[sel] = 1'b0;
		end
	endtask

	task automatic end_load();
		@(negedge clk);
		rom_wr_i = 1'b0;
	endtask

	// two clocks of reset sync, no byte can be fetched yet
	task automatic set_drive_reset(input logic [NUM_DRIVES-1:0] bits);
		@(negedge clk);
		drv_reset_i = bits;
		repeat (2) @(negedge clk);
	endtask

	// track every visible bus change against consecutive bytes
	task automatic follow_serial(input drive_model_e model, input int end_addr);
		int         skip;
		int         n;
		logic       done;
		logic [3:0] want;
		done = 1'b0;
		while (!done) begin
			skip = 0;
			while ((exp_addr + skip < end_addr) &&
			       (bus_fields(image_byte(model, exp_addr + skip)) == prev_bus))
				skip++;
			if (exp_addr + skip >= end_addr) begin
				done = 1'b1;
			end else begin
				want = bus_fields(image_byte(model, exp_addr + skip));
				for (n = 0; n < (skip + 1) * 16 + 40; n++) begin
					@(negedge clk);
					if (bus_state() != prev_bus)
						break;
				end
				if (bus_state() == prev_bus)
					stop_run($sformatf("timeout waiting for serial byte at %h", exp_addr + skip));
				check_byte($sformatf("bus fields of byte %h", exp_addr + skip),
				           {4'h0, bus_state()}, {4'h0, want});
				prev_bus = want;
				exp_addr = exp_addr + skip + 1;
			end
		end
	endtask

	task automatic expect_pulse(input drive_model_e model);
		int n;
		for (n = 0; n < 64; n++) begin
			@(negedge clk);
			if (!par_stb_o)
				break;
		end
		if (par_stb_o)
			stop_run($sformatf("no parallel strobe for byte %h", exp_addr));
		check_byte($sformatf("parallel byte %h", exp_addr), par_data_o, image_byte(model, exp_addr));
		exp_addr++;
		@(negedge clk);
		check_bit("parallel strobe width", par_stb_o, 1'b1);
	endtask

	task automatic watch_pulses(input drive_model_e model, input int clocks);
		for (int n = 0; n < clocks; n++) begin
			@(negedge clk);
			if (!par_stb_o) begin
				check_byte($sformatf("parallel byte %h", exp_addr), par_data_o,
				           image_byte(model, exp_addr));
				exp_addr++;
			end
		end
	endtask

	//----------------------------------------------------------
	// directed tests
	//----------------------------------------------------------
	task automatic test_sequence();
		logic [7:0] d;
		@(negedge clk);
		drv_mode[0] = MODEL_1541;
		for (int a = 0; a < 'h200; a++) begin
			d = $random(seed);
			if ((a < 'h100) || (d == 8'hFF))
				d = (a < 'h100) ? 8'hFF : 8'hFE;
			write_rom(0, a, d);
		end
		end_load();
		check_size("1541 image size", i_dut.rom_size[0], exp_size[MODEL_1541]);
		set_drive_reset(only_drive0_run());
		exp_addr = 0;
		prev_bus = bus_state();
		follow_serial(MODEL_1541, 'h200);
		set_drive_reset('1);
	endtask

	task automatic test_parallel();
		@(negedge clk);
		drv_mode[0] = MODEL_1570;
		for (int a = 0; a < 'h2000; a++)
			write_rom(1, a, ($random(seed) & 1) ? 8'hFF : 8'h00);
		write_rom(1, 'h4000, 8'hA5);
		end_load();
		check_size("1570 image size", i_dut.rom_size[0], exp_size[MODEL_1570]);
		set_drive_reset(only_drive0_run());
		exp_addr = 0;
		for (int i = 0; i < 64; i++)
			expect_pulse(MODEL_1570);
		check_bit("1570 parallel enable", i_dut.ext_en[0], expect_ext_en(MODEL_1570, 1'b0));
		// no image and no extension on the 1571CR
		@(negedge clk);
		drv_mode[0] = MODEL_1571CR;
		for (int n = 0; n < 64; n++) begin
			@(negedge clk);
			check_bit("1571CR parallel strobe", par_stb_o, 1'b1);
		end
		check_bit("1571CR parallel enable", i_dut.ext_en[0], expect_ext_en(MODEL_1571CR, 1'b0));
		set_drive_reset('1);
	endtask

	task automatic test_size_mask();
		logic [12:0] a13;
		logic [7:0]  d;
		@(negedge clk);
		drv_mode[0] = MODEL_1541;
		// distinct bytes only around the 8K boundary
		for (int a = 0; a < 'h2000; a++) begin
			a13 = 13'(a);
			d   = QUIET;
			if ((a < 16) || (a >= 'h1FF0))
				d = {4'h1, a13[3:0] ^ a13[7:4] ^ a13[11:8] ^ {3'b000, a13[12]} ^ 4'h5};
			write_rom(0, a, d);
		end
		end_load();
		check_size("8K image size", i_dut.rom_size[0], exp_size[MODEL_1541]);
		set_drive_reset(only_drive0_run());
		check_bit("8K parallel enable", i_dut.ext_en[0], expect_ext_en(MODEL_1541, 1'b0));
		check_byte("8K parallel data", par_data_o, 8'hFF);
		exp_addr = 0;
		prev_bus = bus_state();
		follow_serial(MODEL_1541, 'h2010);
	endtask

	task automatic test_atn_ack();
		int n;
		// move into the quiet stretch after the wrap
		repeat (400) @(negedge clk);
		check_bit("data before ATN", iec_data_o, QUIET[BIT_DATA]);
		iec_atn_i = 1'b0;
		for (n = 0; n < 4; n++) begin
			@(negedge clk);
			if (!iec_data_o)
				break;
		end
		check_bit("data acknowledging ATN", iec_data_o, 1'b0);
		repeat (8) @(negedge clk);
		check_bit("data held during ATN", iec_data_o, 1'b0);
		iec_atn_i = 1'b1;
		for (n = 0; n < 4; n++) begin
			@(negedge clk);
			if (iec_data_o)
				break;
		end
		check_bit("data after ATN release", iec_data_o, QUIET[BIT_DATA]);
	endtask

	task automatic test_reset_release();
		@(negedge clk);
		drv_reset_i = '1;
		for (int n = 0; n < 4; n++) begin
			@(negedge clk);
			if (iec_data_o && iec_clk_o && iec_fclk_o && (led_o == '0) && (par_data_o == 8'hFF))
				break;
		end
		check_bit("released data", iec_data_o, 1'b1);
		check_bit("released clock", iec_clk_o, 1'b1);
		check_bit("released fast clock", iec_fclk_o, 1'b1);
		check_byte("LEDs in reset", 8'(led_o), 8'h00);
		check_byte("parallel data in reset", par_data_o, 8'hFF);
	endtask

	task automatic test_pause();
		logic [7:0] held_par;
		logic [3:0] held_bus;
		@(negedge clk);
		drv_mode[0] = MODEL_1570;
		set_drive_reset(only_drive0_run());
		exp_addr = 0;
		for (int i = 0; i < 4; i++)
			expect_pulse(MODEL_1570);
		pause_i = 1'b1;
		watch_pulses(MODEL_1570, 40);
		held_par = par_data_o;
		held_bus = bus_state();
		for (int n = 0; n < 200; n++) begin
			@(negedge clk);
			check_bit("strobe while paused", par_stb_o, 1'b1);
			check_byte("parallel data while paused", par_data_o, held_par);
			check_byte("bus while paused", {4'h0, bus_state()}, {4'h0, held_bus});
		end
		pause_i = 1'b0;
		for (int i = 0; i < 4; i++)
			expect_pulse(MODEL_1570);
		set_drive_reset('1);
	endtask

	//----------------------------------------------------------
	// main sequence
	//----------------------------------------------------------
	initial begin
		seed        = 32'h523b;
		fail_count  = 0;
		rst_n_i     = 1'b0;
		ce_i        = 1'b1;
		pause_i     = 1'b0;
		drv_reset_i = '1;
		for (int d = 0; d < NUM_DRIVES; d++)
			drv_mode[d] = MODEL_1541;
		iec_atn_i   = 1'b1;
		iec_data_i  = 1'b1;
		iec_clk_i   = 1'b1;
		iec_fclk_i  = 1'b1;
		par_data_i  = 8'hFF;
		par_stb_i   = 1'b1;
		rom_sel_i   = '0;
		rom_addr_i  = '0;
		rom_data_i  = 8'h00;
		rom_wr_i    = 1'b0;
		exp_size[0] = ROM_8K;
		for (int i = 0; i < NUM_ROMS; i++) begin
			if (i > 0)
				exp_size[i] = ROM_32K;
			exp_empty8k[i] = 1'b0;
		end

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		repeat (40) @(negedge clk);

		test_sequence();
		test_parallel();
		test_size_mask();
		test_atn_ack();
		test_reset_release();
		test_pause();

		if (fail_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
